//--- run.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module cpuTb -f tb.f -o cpuSim \
    && ./obj_dir/cpuSim | tee sim.log
grep -q "All tests passed!" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- src/aluUnit.sv
`default_nettype none

module aluUnit (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t busIn,
    output cpuPkg::word_t zLow
);
    import cpuPkg::*;

    word_t y;
    word_t z;
    word_t result;

    // Y is always the A operand, bus the B operand
    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   result = y + busIn;
            aluSub:   result = y - busIn;
            aluAnd:   result = y & busIn;
            aluOr:    result = y | busIn;
            aluIncPc: result = busIn + 1'b1;
            default:  result = busIn;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            y <= '0;
            z <= '0;
        end else begin
            if (ctrl.yIn) begin
                y <= busIn;
            end
            if (ctrl.zIn) begin
                z <= result;
            end
        end
    end

    assign zLow = z;

endmodule

`default_nettype wire

//--- src/busDatapath.sv
`default_nettype none

module busDatapath (
    input  logic            clock,
    input  logic            rstN,
    input  cpuPkg::ctrl_t   ctrl,
    output cpuPkg::opcode_t opcode,
    output logic            memDone,
    output cpuPkg::wbReq_t  wbReq,
    input  cpuPkg::wbRsp_t  wbRsp
);
    import cpuPkg::*;

    word_t  pc;
    word_t  ir;
    word_t  bus;
    word_t  cSign;
    word_t  regOut;
    word_t  zLow;
    word_t  mdr;
    instr_t instr;

    assign instr  = ir;
    assign opcode = instr.opcode;

    // C sign extended to a full word
    assign cSign = {{($bits(word_t) - CWidth){ir[CWidth-1]}}, ir[CWidth-1:0]};

    // Single internal bus
    always_comb begin
        case (ctrl.busSrc)
            srcPc:    bus = pc;
            srcZLow:  bus = zLow;
            srcMdr:   bus = mdr;
            srcReg:   bus = regOut;
            srcCSign: bus = cSign;
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
        end
    end

    registerFile regFile_i (
        .clock  (clock),
        .rstN   (rstN),
        .ir     (ir),
        .ctrl   (ctrl),
        .busIn  (bus),
        .regOut (regOut)
    );

    aluUnit alu_i (
        .clock (clock),
        .rstN  (rstN),
        .ctrl  (ctrl),
        .busIn (bus),
        .zLow  (zLow)
    );

    memInterface mem_i (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busIn   (bus),
        .mdr     (mdr),
        .memDone (memDone),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp)
    );

endmodule

`default_nettype wire

//--- src/controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  logic            clock,
    input  logic            rstN,
    input  cpuPkg::opcode_t opcode,
    input  logic            memDone,
    output cpuPkg::ctrl_t   ctrl,
    output logic            halted
);
    import cpuPkg::*;

    state_t state;
    state_t stateNext;
    logic   isLd;
    logic   isSt;
    logic   isImm;

    assign isLd  = (opcode == opLd);
    assign isSt  = (opcode == opSt);
    assign isImm = isLd || isSt || (opcode == opLdi) || (opcode == opAddi);  // Uses rb' + c

    always_comb begin
        stateNext = state;
        case (state)
            stReset: stateNext = stT0;
            stT0:    stateNext = stT1;
            stT1: begin
                if (memDone) begin
                    stateNext = stT2;   // Fetch done
                end
            end
            stT2:    stateNext = stT3;
            stT3:    stateNext = (opcode == opHalt) ? stHalted : stT4;
            stT4:    stateNext = stT5;
            stT5:    stateNext = (isLd || isSt) ? stT6 : stT0;
            stT6: begin
                if (isSt || memDone) begin
                    stateNext = stT7;
                end
            end
            stT7: begin
                if (isLd || memDone) begin
                    stateNext = stT0;
                end
            end
            default: stateNext = stHalted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state  <= stReset;
            halted <= 1'b0;
        end else begin
            state <= stateNext;
            if (stateNext == stHalted) begin
                halted <= 1'b1;
            end
        end
    end

    // Strobes decoded from the registered state
    always_comb begin
        ctrl = '0;
        case (state)
            stT0: begin
                ctrl.busSrc = srcPc;
                ctrl.marIn  = 1'b1;
                ctrl.zIn    = 1'b1;
                ctrl.aluOp  = aluIncPc;
            end
            stT1: begin
                ctrl.busSrc  = srcZLow;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            stT2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irIn   = 1'b1;
            end
            stT3: begin
                if (opcode != opHalt) begin
                    ctrl.busSrc = srcReg;
                    ctrl.regSel = selRb;
                    ctrl.baOut  = isImm;
                    ctrl.yIn    = 1'b1;
                end
            end
            stT4: begin
                ctrl.zIn = 1'b1;
                if (isImm) begin
                    ctrl.busSrc = srcCSign;
                    ctrl.aluOp  = aluAdd;
                end else begin
                    ctrl.busSrc = srcReg;
                    ctrl.regSel = selRc;
                    case (opcode)
                        opSub:   ctrl.aluOp = aluSub;
                        opAnd:   ctrl.aluOp = aluAnd;
                        opOr:    ctrl.aluOp = aluOr;
                        default: ctrl.aluOp = aluAdd;
                    endcase
                end
            end
            stT5: begin
                ctrl.busSrc = srcZLow;
                if (isLd || isSt) begin
                    ctrl.marIn = 1'b1;   // Effective address
                end else begin
                    ctrl.regSel = selRa;
                    ctrl.rIn    = 1'b1;
                end
            end
            stT6: begin
                ctrl.mdrIn = 1'b1;
                if (isLd) begin
                    ctrl.memRead = 1'b1;
                end else begin
                    ctrl.busSrc = srcReg;   // Store data from ra
                    ctrl.regSel = selRa;
                end
            end
            stT7: begin
                if (isLd) begin
                    ctrl.busSrc = srcMdr;
                    ctrl.regSel = selRa;
                    ctrl.rIn    = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int NumRegs = 16;
    localparam int CWidth  = 19;   // Constant field, bits 18..0

    typedef logic [31:0] word_t;
    typedef logic [8:0]  addr_t;
    typedef logic [3:0]  regIdx_t;

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opHalt = 5'b11011
    } opcode_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluIncPc   // Bus plus one
    } aluOp_t;

    typedef enum logic [2:0] {
        srcNone,
        srcPc,
        srcZLow,
        srcMdr,
        srcReg,
        srcCSign
    } busSrc_t;

    typedef enum logic [3:0] {
        stReset,
        stT0,
        stT1,
        stT2,
        stT3,
        stT4,
        stT5,
        stT6,
        stT7,
        stHalted
    } state_t;

    // Gra, Grb, Grc
    typedef enum logic [1:0] {
        selRa,
        selRb,
        selRc
    } regSel_t;

    typedef struct packed {
        opcode_t opcode;   // 31..27
        regIdx_t ra;       // 26..23
        regIdx_t rb;       // 22..19
        regIdx_t rc;       // 18..15
        logic [CWidth-$bits(regIdx_t)-1:0] cLow;
    } instr_t;

    typedef struct packed {
        busSrc_t busSrc;
        regSel_t regSel;
        logic    baOut;
        logic    rIn;
        logic    pcIn;
        logic    irIn;
        logic    marIn;
        logic    mdrIn;
        logic    yIn;
        logic    zIn;
        aluOp_t  aluOp;
        logic    memRead;
        logic    memWrite;
    } ctrl_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wbReq_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wbRsp_t;

endpackage

`default_nettype wire

//--- src/cpuTop.sv
`default_nettype none

module cpuTop (
    input  logic           clock,
    input  logic           rstN,
    output cpuPkg::wbReq_t wbReq,
    input  cpuPkg::wbRsp_t wbRsp,
    output logic           halted
);
    import cpuPkg::*;

    ctrl_t   ctrl;
    opcode_t opcode;
    logic    memDone;   // Transfer complete

    controlSequencer seq_i (
        .clock   (clock),
        .rstN    (rstN),
        .opcode  (opcode),
        .memDone (memDone),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    busDatapath dp_i (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .opcode  (opcode),
        .memDone (memDone),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp)
    );

endmodule

`default_nettype wire

//--- src/memInterface.sv
`default_nettype none

module memInterface (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::ctrl_t  ctrl,
    input  cpuPkg::word_t  busIn,
    output cpuPkg::word_t  mdr,
    output logic           memDone,
    output cpuPkg::wbReq_t wbReq,
    input  cpuPkg::wbRsp_t wbRsp
);
    import cpuPkg::*;

    addr_t mar;
    logic  busy;
    logic  weQ;
    logic  start;
    logic  ackSeen;

    assign ackSeen = busy && wbRsp.ack;
    assign start   = (ctrl.memRead || ctrl.memWrite) && !busy;

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= busIn[$bits(addr_t)-1:0];   // Word address from the low bits
        end
        if (ackSeen && !weQ) begin
            mdr <= wbRsp.dat;                  // Read data on the ack edge
        end else if (ctrl.mdrIn && !ctrl.memRead) begin
            mdr <= busIn;
        end
    end

    // One classic cycle per request
    always_ff @(posedge clock) begin
        if (!rstN) begin
            busy <= 1'b0;
            weQ  <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            weQ  <= ctrl.memWrite;
        end else if (ackSeen) begin
            busy <= 1'b0;
            weQ  <= 1'b0;
        end
    end

    // Sequencer steps on the same edge the strobes drop
    assign memDone = ackSeen;

    assign wbReq.cyc = busy;
    assign wbReq.stb = busy;
    assign wbReq.we  = weQ;
    assign wbReq.adr = mar;   // MAR and MDR hold while busy
    assign wbReq.dat = mdr;

endmodule

`default_nettype wire

//--- src/registerFile.sv
`default_nettype none

module registerFile (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::word_t ir,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t busIn,
    output cpuPkg::word_t regOut
);
    import cpuPkg::*;

    instr_t  instr;
    regIdx_t sel;
    word_t   regs [NumRegs];

    assign instr = ir;

    // Register select from the IR fields
    always_comb begin
        case (ctrl.regSel)
            selRa:   sel = instr.ra;
            selRb:   sel = instr.rb;
            default: sel = instr.rc;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[sel] <= busIn;
        end
    end

    // BA out reads R0 as zero
    assign regOut = (ctrl.baOut && sel == '0) ? '0 : regs[sel];

endmodule

`default_nettype wire

//--- tb.f
+incdir+testbench
src/cpuPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/memInterface.sv
src/busDatapath.sv
src/controlSequencer.sv
src/cpuTop.sv
testbench/cpuTb.sv

//--- testbench/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int DumpBase = 128;   // Register dump area
localparam int DataBase = 256;

integer seed;
word_t  progWords [$];
word_t  modelMem [512];
word_t  modelRegs [NumRegs];
addr_t  expReadAddr [$];
bit     expReadIsLoad [$];
addr_t  expWriteAddr [$];
word_t  expWriteData [$];

function automatic word_t randomWord();
    return $random(seed);
endfunction

function automatic regIdx_t randomReg();
    word_t r;
    r = randomWord();
    return r[3:0];
endfunction

// opcode | ra | rb | c, with rc in the top of c
function automatic word_t encodeInstr(opcode_t op, regIdx_t ra, regIdx_t rb, logic [18:0] c);
    return {op, ra, rb, c};
endfunction

task automatic buildProgram();
    word_t       r;
    word_t       c;
    regIdx_t     ra;
    regIdx_t     rb;
    logic [18:0] dataAdr;
    for (int i = 0; i < NumRegs; i++) begin
        r = randomWord();
        rb = r[20] ? 4'd0 : randomReg();
        progWords.push_back(encodeInstr(opLdi, regIdx_t'(i), rb, r[18:0]));
    end
    for (int i = 0; i < 60; i++) begin
        r = randomWord();
        c = randomWord();
        ra = randomReg();
        rb = r[4] ? randomReg() : 4'd0;   // Zero base half the time
        dataAdr = {10'd0, 1'b1, r[15:8]};  // 256..511
        case (r[2:0])
            3'd0: progWords.push_back(encodeInstr(opLd, ra, 4'd0, dataAdr));
            3'd1: progWords.push_back(encodeInstr(opSt, ra, 4'd0, dataAdr));
            3'd2: progWords.push_back(encodeInstr(opLdi, ra, rb, c[18:0]));
            3'd3: progWords.push_back(encodeInstr(opAddi, ra, rb, c[18:0]));
            3'd4: progWords.push_back(encodeInstr(opAdd, ra, rb, {randomReg(), 15'd0}));
            3'd5: progWords.push_back(encodeInstr(opSub, ra, rb, {randomReg(), 15'd0}));
            3'd6: progWords.push_back(encodeInstr(opAnd, ra, rb, {randomReg(), 15'd0}));
            default: progWords.push_back(encodeInstr(opOr, ra, rb, {randomReg(), 15'd0}));
        endcase
    end
    for (int i = 0; i < NumRegs; i++) begin
        progWords.push_back(encodeInstr(opSt, regIdx_t'(i), 4'd0, 19'(DumpBase + i)));
    end
    progWords.push_back(encodeInstr(opHalt, 4'd0, 4'd0, 19'd0));
endtask

task automatic initMemory();
    for (int a = 0; a < 512; a++) begin
        modelMem[a] = 32'hbad0_0000 | a;
        if (a >= DataBase) begin
            modelMem[a] = randomWord();
        end
        if (a < progWords.size()) begin
            modelMem[a] = progWords[a];
        end
    end
endtask

// Instruction-level model, logs every read and store in order
task automatic runModel();
    word_t   pc;
    word_t   w;
    word_t   base;
    word_t   c;
    word_t   sum;
    opcode_t op;
    regIdx_t ra;
    regIdx_t rb;
    regIdx_t rc;
    addr_t   ea;
    bit      done;
    pc = '0;
    done = 1'b0;
    for (int i = 0; i < NumRegs; i++) begin
        modelRegs[i] = '0;
    end
    while (!done) begin
        expReadAddr.push_back(pc[8:0]);
        expReadIsLoad.push_back(1'b0);
        w = modelMem[pc[8:0]];
        pc = pc + 32'd1;
        op = opcode_t'(w[31:27]);
        ra = w[26:23];
        rb = w[22:19];
        rc = w[18:15];
        base = (rb == 4'd0) ? '0 : modelRegs[rb];   // BA out rule
        c = {{13{w[18]}}, w[18:0]};
        sum = base + c;
        ea = sum[8:0];
        case (op)
            opLd: begin
                expReadAddr.push_back(ea);
                expReadIsLoad.push_back(1'b1);
                modelRegs[ra] = modelMem[ea];
            end
            opSt: begin
                expWriteAddr.push_back(ea);
                expWriteData.push_back(modelRegs[ra]);
                modelMem[ea] = modelRegs[ra];
            end
            opLdi, opAddi: modelRegs[ra] = sum;
            opAdd:   modelRegs[ra] = modelRegs[rb] + modelRegs[rc];
            opSub:   modelRegs[ra] = modelRegs[rb] - modelRegs[rc];
            opAnd:   modelRegs[ra] = modelRegs[rb] & modelRegs[rc];
            opOr:    modelRegs[ra] = modelRegs[rb] | modelRegs[rc];
            default: done = 1'b1;
        endcase
    end
endtask

`endif

//--- testbench/cpuTb.sv
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int ProgLen    = 2 * NumRegs + 60 + 1;
    localparam int CycleLimit = ProgLen * (8 + 2 * 3 + 3) + 100;

    logic   clock;
    logic   rstN;
    wbReq_t wbReq;
    wbRsp_t wbRsp;
    logic   halted;

    word_t  mem [512];   // Slave memory
    wbReq_t heldReq;
    logic   inXfer;
    logic   ackedLast;
    int     waitLeft;
    int     readIdx;
    int     writeIdx;
    int     cycleCount = 0;

    `include "cpuModel.svh"

    cpuTop dut_i (
        .clock  (clock),
        .rstN   (rstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .halted (halted)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic compareValue(string testName, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", testName, expected, actual);
            $display("Test failures found");
            $fatal(1, "%s mismatch", testName);
        end
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Run aborted");
    endtask

    // New request checked against the model's order
    task automatic startTransfer();
        int dumpReg;
        inXfer = 1'b1;
        heldReq = wbReq;
        waitLeft = {$random(seed)} % 4;
        if (wbReq.we) begin
            if (writeIdx >= expWriteAddr.size()) begin
                abortRun("A store appeared that the program does not make");
            end
            dumpReg = writeIdx - (expWriteAddr.size() - NumRegs);
            if (dumpReg >= 0) begin
                compareValue("regDumpAddr", 64'(expWriteAddr[writeIdx]), 64'(wbReq.adr));
                compareValue("regDumpData", 64'(modelRegs[dumpReg]), 64'(wbReq.dat));
            end else begin
                compareValue("storeAddr", 64'(expWriteAddr[writeIdx]), 64'(wbReq.adr));
                compareValue("storeData", 64'(expWriteData[writeIdx]), 64'(wbReq.dat));
            end
            writeIdx++;
        end else begin
            if (readIdx >= expReadAddr.size()) begin
                abortRun("A read appeared after the end of the program");
            end
            if (readIdx == 0) begin
                compareValue("firstFetchAddr", 64'd0, 64'(wbReq.adr));
            end
            if (expReadIsLoad[readIdx]) begin
                compareValue("loadAddr", 64'(expReadAddr[readIdx]), 64'(wbReq.adr));
            end else begin
                compareValue("fetchAddr", 64'(expReadAddr[readIdx]), 64'(wbReq.adr));
            end
            readIdx++;
        end
    endtask

    task automatic finishTransfer();
        wbRsp.ack = 1'b1;
        if (heldReq.we) begin
            mem[heldReq.adr] = heldReq.dat;
        end else begin
            wbRsp.dat = mem[heldReq.adr];
        end
        inXfer = 1'b0;
        ackedLast = 1'b1;
    endtask

    // Wishbone slave with 0..3 wait cycles
    always @(negedge clock) begin
        wbRsp.ack = 1'b0;
        wbRsp.dat = '0;
        if (ackedLast) begin
            compareValue("cycAfterAck", 64'd0, 64'(wbReq.cyc));   // One transfer per ack
            compareValue("stbAfterAck", 64'd0, 64'(wbReq.stb));
            ackedLast = 1'b0;
        end
        if (inXfer) begin
            compareValue("reqStable", 64'(heldReq), 64'(wbReq));   // Held until ack
        end else if (wbReq.cyc && wbReq.stb) begin
            startTransfer();
        end else if (wbReq.cyc || wbReq.stb) begin
            abortRun("The master raised cyc and stb separately");
        end
        if (inXfer) begin
            if (waitLeft == 0) begin
                finishTransfer();
            end else begin
                waitLeft--;
            end
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            abortRun("Timeout: the CPU did not reach halt within the cycle limit");
        end
    end

    initial begin
        seed = 32'hc2cd;
        rstN = 1'b0;
        wbRsp = '0;
        inXfer = 1'b0;
        ackedLast = 1'b0;
        waitLeft = 0;
        readIdx = 0;
        writeIdx = 0;
        buildProgram();
        initMemory();
        mem = modelMem;
        runModel();

        repeat (5) begin
            @(negedge clock);
            compareValue("resetCyc", 64'd0, 64'(wbReq.cyc));
            compareValue("resetStb", 64'd0, 64'(wbReq.stb));
            compareValue("resetHalted", 64'd0, 64'(halted));
        end
        rstN = 1'b1;
        @(negedge clock);
        compareValue("postResetCyc", 64'd0, 64'(wbReq.cyc));
        compareValue("postResetStb", 64'd0, 64'(wbReq.stb));
        compareValue("postResetHalted", 64'd0, 64'(halted));

        while (halted !== 1'b1) begin
            @(negedge clock);
        end
        repeat (20) begin
            @(negedge clock);
            compareValue("haltedHigh", 64'd1, 64'(halted));
            compareValue("cycAfterHalt", 64'd0, 64'(wbReq.cyc));
        end

        if (readIdx == expReadAddr.size() && writeIdx == expWriteAddr.size()) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Halted early: %0d of %0d reads and %0d of %0d stores seen",
                     readIdx, expReadAddr.size(), writeIdx, expWriteAddr.size());
            $display("Test failures found");
            $fatal(1, "Missing transfers");
        end
    end

endmodule

`default_nettype wire
